// File: usbf_pkg.sv
`default_nettype none

package usbf_pkg;

	// Token PIDs
	localparam logic [3:0] pid_out     = 4'b0001;
	localparam logic [3:0] pid_in      = 4'b1001;
	localparam logic [3:0] pid_sof     = 4'b0101;
	localparam logic [3:0] pid_setup   = 4'b1101;

	// Data PIDs
	localparam logic [3:0] pid_data0   = 4'b0011;
	localparam logic [3:0] pid_data1   = 4'b1011;
	localparam logic [3:0] pid_data2   = 4'b0111;
	localparam logic [3:0] pid_mdata   = 4'b1111;

	// Handshakes
	localparam logic [3:0] pid_ack     = 4'b0010;
	localparam logic [3:0] pid_nack    = 4'b1010;
	localparam logic [3:0] pid_stall   = 4'b1110;
	localparam logic [3:0] pid_nyet    = 4'b0110;

	// Specials, PRE and ERR share one code
	localparam logic [3:0] pid_pre_err = 4'b1100;
	localparam logic [3:0] pid_split   = 4'b1000;
	localparam logic [3:0] pid_ping    = 4'b0100;

	localparam int mem_aw     = 10;	// Word address bits
	localparam int fifo_depth = 16;	// Bytes in rx FIFO
	localparam int fifo_aw    = 4;	// log2 of fifo_depth

	// Half microsecond divider, small value for simulation
	localparam int hms_del    = 3;
	localparam int frm_nat_w  = 32;	// Frame/time word

	// Packet decoder states
	localparam logic [2:0] st_idle  = 3'd0;	// Between packets
	localparam logic [2:0] st_pid   = 3'd1;	// Waiting for PID byte
	localparam logic [2:0] st_token = 3'd2;	// Two token bytes
	localparam logic [2:0] st_data  = 3'd3;	// Payload and CRC16
	localparam logic [2:0] st_skip  = 3'd4;	// Ignore rest of packet

	// 11 bits after a token PID
	// IN/OUT/SETUP carry address and endpoint, SOF a frame number
	typedef union packed {
		struct packed {
			logic [3:0] endp;	// Upper four bits
			logic [6:0] fadr;	// Function address
		} tok;
		logic [10:0] frm;	// SOF frame number
	} token_field_t;

endpackage

`default_nettype wire

// File: usbf_pd.sv
`default_nettype none

module usbf_pd (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [7:0]            rx_data,
	input  logic                  rx_valid,
	input  logic                  rx_active,
	input  logic                  rx_err,
	input  logic [6:0]            fa,		// Our function address
	input  logic                  mode_hs,
	input  logic                  fifo_ready,
	output logic [7:0]            pd_data,
	output logic                  pd_last,
	output logic                  pd_valid,
	output usbf_pkg::token_field_t token_field,
	output logic [3:0]            token_pid,
	output logic                  token_valid,
	output logic                  token_match,
	output logic                  sof_we,
	output logic                  pid_cs_err,
	output logic                  crc5_err,
	output logic                  unsupported_pid,
	output logic                  drop_err
);

	logic [2:0] state;
	logic       rx_byte, pid_take;
	logic [3:0] rx_pid;
	logic       pid_ok, is_token, is_data, pid_bad;
	logic [3:0] pid_r;		// PID of packet in progress
	logic [7:0] tok_b0, tok_b1;
	logic [1:0] tcnt;		// Token bytes seen
	logic [4:0] crc_r;
	logic       crc_ok, addr_hit, tok_end, tok_byte;
	usbf_pkg::token_field_t tok_w;
	logic       data_en;	// Matching OUT/SETUP seen
	logic [7:0] h0, h1, h2;	// h0 oldest
	logic [1:0] hc;		// Held byte count
	logic       dat_byte, dat_end, emit;

	// Bitwise x^5+x^2+1 update with LSB first
	function automatic logic [4:0] crc5_upd(input logic [4:0] crc, input logic [7:0] d,
		input logic [3:0] n);
		logic [4:0] c;
		logic       fb;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			if (i < n) begin
				fb = c[4] ^ d[i];
				c = {c[3:0], 1'b0} ^ (fb ? 5'b00101 : 5'b00000);
			end
		end
		return c;
	endfunction

	assign rx_byte  = rx_active & rx_valid;
	assign pid_take = rx_byte & (state == usbf_pkg::st_idle | state == usbf_pkg::st_pid);
	assign rx_pid   = rx_data[3:0];
	assign pid_ok   = rx_data[7:4] == ~rx_data[3:0];	// Check nibble
	assign is_token = rx_pid == usbf_pkg::pid_out | rx_pid == usbf_pkg::pid_in |
		rx_pid == usbf_pkg::pid_sof | rx_pid == usbf_pkg::pid_setup;
	assign is_data  = rx_pid == usbf_pkg::pid_data0 | rx_pid == usbf_pkg::pid_data1 |
		rx_pid == usbf_pkg::pid_data2 | rx_pid == usbf_pkg::pid_mdata;
	// Never expected by a function
	assign pid_bad  = rx_pid == usbf_pkg::pid_ack | rx_pid == usbf_pkg::pid_nack |
		rx_pid == usbf_pkg::pid_stall | rx_pid == usbf_pkg::pid_nyet |
		rx_pid == usbf_pkg::pid_pre_err | rx_pid == usbf_pkg::pid_split |
		(rx_pid == usbf_pkg::pid_ping & ~mode_hs);	// PING is HS only

	// Endp straddles the two token bytes
	assign tok_w    = usbf_pkg::token_field_t'({tok_b1[2:0], tok_b0});
	assign crc_ok   = tok_b1[7:3] == ~crc_r;
	assign addr_hit = tok_w.tok.fadr == fa;
	assign tok_byte = state == usbf_pkg::st_token & rx_byte & ~rx_err & tcnt != 2'd2;
	assign tok_end  = state == usbf_pkg::st_token & ~rx_active;
	assign dat_byte = state == usbf_pkg::st_data & rx_byte & ~rx_err;
	assign dat_end  = state == usbf_pkg::st_data & ~rx_active;
	// With three held h0 is payload and h1/h2 may be CRC16
	assign emit     = data_en & hc == 2'd3 & (dat_byte | dat_end);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state           <= usbf_pkg::st_idle;
			tcnt            <= 2'd0;
			hc              <= 2'd0;
			data_en         <= 1'b0;
			pid_cs_err      <= 1'b0;
			unsupported_pid <= 1'b0;
			token_valid     <= 1'b0;
			token_match     <= 1'b0;
			crc5_err        <= 1'b0;
			sof_we          <= 1'b0;
			pd_valid        <= 1'b0;
			drop_err        <= 1'b0;
		end else begin
			pid_cs_err      <= 1'b0;	// Pulses by default
			unsupported_pid <= 1'b0;
			token_valid     <= 1'b0;
			token_match     <= 1'b0;
			crc5_err        <= 1'b0;
			sof_we          <= 1'b0;
			pd_valid        <= emit;
			drop_err        <= pd_valid & ~fifo_ready;	// Byte lost
			if (pid_take) begin
				tcnt            <= 2'd0;
				hc              <= 2'd0;
				pid_cs_err      <= ~pid_ok;
				unsupported_pid <= pid_ok & pid_bad;
				if (rx_err || !pid_ok)
					state <= usbf_pkg::st_skip;
				else if (is_token)
					state <= usbf_pkg::st_token;
				else if (is_data)
					state <= usbf_pkg::st_data;
				else
					state <= usbf_pkg::st_skip;
			end else begin
				case (state)
					usbf_pkg::st_idle: if (rx_active) state <= usbf_pkg::st_pid;
					usbf_pkg::st_pid: begin
						if (!rx_active)
							state <= usbf_pkg::st_idle;
						else if (rx_err)
							state <= usbf_pkg::st_skip;
					end
					usbf_pkg::st_token: begin
						if (tok_end) begin
							state <= usbf_pkg::st_idle;
							data_en <= 1'b0;
							if (tcnt == 2'd2) begin	// Complete token
								token_valid <= 1'b1;
								crc5_err    <= ~crc_ok;
								token_match <= crc_ok & addr_hit & pid_r != usbf_pkg::pid_sof;
								sof_we      <= crc_ok & pid_r == usbf_pkg::pid_sof;
								data_en     <= crc_ok & addr_hit &
									(pid_r == usbf_pkg::pid_out | pid_r == usbf_pkg::pid_setup);
							end
						end else if (rx_err || (rx_byte && tcnt == 2'd2))
							state <= usbf_pkg::st_skip;	// Too long or broken
						else if (tok_byte)
							tcnt <= tcnt + 2'd1;
					end
					usbf_pkg::st_data: begin
						if (dat_end || rx_err) begin
							data_en <= 1'b0;	// One data packet per token
							state   <= dat_end ? usbf_pkg::st_idle : usbf_pkg::st_skip;
						end else if (dat_byte && hc != 2'd3)
							hc <= hc + 2'd1;
					end
					usbf_pkg::st_skip: if (!rx_active) state <= usbf_pkg::st_idle;
					default: state <= usbf_pkg::st_idle;
				endcase
			end
		end
	end

	// Token bytes, CRC5 and payload pipeline
	always_ff @(posedge clk) begin
		if (pid_take)
			pid_r <= rx_pid;
		if (tok_byte) begin
			if (tcnt == 2'd0) begin
				tok_b0 <= rx_data;
				crc_r  <= crc5_upd(5'h1f, rx_data, 4'd8);	// Preset all ones
			end else begin
				tok_b1 <= rx_data;
				crc_r  <= crc5_upd(crc_r, rx_data, 4'd3);	// Endp top bits only
			end
		end
		if (tok_end) begin
			token_field <= tok_w;
			token_pid   <= pid_r;
		end
		if (dat_byte) begin
			h0 <= h1;
			h1 <= h2;
			h2 <= rx_data;
		end
		if (emit) begin
			pd_data <= h0;
			pd_last <= dat_end;	// Final payload byte at packet end
		end
	end

endmodule

`default_nettype wire

// File: usbf_rx_fifo.sv
`default_nettype none

module usbf_rx_fifo (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] wr_data,
	input  logic       wr_last,
	input  logic       wr_valid,
	output logic       wr_ready,
	output logic [7:0] rd_data,
	output logic       rd_last,
	output logic       rd_valid,
	input  logic       rd_ready
);

	logic [8:0]                 mem [usbf_pkg::fifo_depth];	// {last, byte}
	logic [usbf_pkg::fifo_aw-1:0] wp, rp;
	logic [usbf_pkg::fifo_aw:0]   cnt;	// One extra bit for full
	logic                       wr_en, rd_en;

	assign wr_ready = cnt != (usbf_pkg::fifo_aw + 1)'(usbf_pkg::fifo_depth);
	assign rd_valid = cnt != '0;
	assign wr_en    = wr_valid & wr_ready;
	assign rd_en    = rd_valid & rd_ready;

	// Head entry held until taken
	assign rd_data  = mem[rp][7:0];
	assign rd_last  = mem[rp][8];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wp] <= {wr_last, wr_data};
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wp  <= '0;
			rp  <= '0;
			cnt <= '0;
		end else begin
			if (wr_en)
				wp <= wp + 1'b1;	// Wraps at depth
			if (rd_en)
				rp <= rp + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   cnt <= cnt + 1'b1;
				2'b01:   cnt <= cnt - 1'b1;
				default: cnt <= cnt;	// Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: usbf_idma.sv
`default_nettype none

module usbf_idma (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [7:0]                 in_data,
	input  logic                       in_last,
	input  logic                       in_valid,
	output logic                       in_ready,
	output logic [usbf_pkg::mem_aw-1:0] madr,	// Word address
	output logic [31:0]                mdout,
	output logic                       mwe,
	output logic                       mreq,
	input  logic                       mack,
	output logic                       idma_done
);

	logic [1:0] lane;	// Next byte lane in word
	logic       wlast;	// Word ends the packet
	logic       take;

	// No new byte while a word is out
	assign in_ready  = ~mreq;
	assign take      = in_valid & in_ready;

	// Last word of packet written
	assign idma_done = mreq & mack & wlast;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			mreq  <= 1'b0;
			mwe   <= 1'b0;
			madr  <= '0;
			mdout <= '0;
			lane  <= 2'd0;
			wlast <= 1'b0;
		end else if (mreq) begin
			// Hold address and data until acknowledged
			if (mack) begin
				mreq  <= 1'b0;
				mwe   <= 1'b0;
				madr  <= madr + 1'b1;
				mdout <= '0;	// Zero lanes for next partial word
			end
		end else if (take) begin
			mdout[lane*8 +: 8] <= in_data;	// Little endian
			wlast              <= in_last;
			if (lane == 2'd3 || in_last) begin
				// Word full or packet done
				mreq <= 1'b1;
				mwe  <= 1'b1;
				lane <= 2'd0;
			end else begin
				lane <= lane + 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: usbf_frame.sv
`default_nettype none

module usbf_frame (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          sof_we,	// Good SOF seen
	input  usbf_pkg::token_field_t        token_field,
	output logic [usbf_pkg::frm_nat_w-1:0] frm_nat
);

	logic        sof_we_r;
	logic        frame_same;	// SOF repeats current frame
	logic [10:0] frame_no_r;
	logic [3:0]  mfm_cnt;	// Microframe count
	logic [11:0] sof_time;	// Half us ticks since SOF
	logic [4:0]  hms_cnt;
	logic        hms_tick;

	assign hms_tick = hms_cnt == 5'(usbf_pkg::hms_del);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sof_we_r   <= 1'b0;
			frame_same <= 1'b0;
			frame_no_r <= 11'h0;
			mfm_cnt    <= 4'h0;
			sof_time   <= 12'h0;
			hms_cnt    <= 5'h0;
		end else begin
			sof_we_r   <= sof_we;
			// Compare before the new number is loaded
			frame_same <= sof_we & (frame_no_r == token_field.frm);
			if (sof_we_r) begin
				frame_no_r <= token_field.frm;
				mfm_cnt    <= frame_same ? mfm_cnt + 4'h1 : 4'h0;
			end
			// Divider restarts with each SOF
			if (sof_we_r || hms_tick)
				hms_cnt <= 5'h0;
			else
				hms_cnt <= hms_cnt + 5'h1;
			if (sof_we_r)
				sof_time <= 12'h0;
			else if (hms_tick)
				sof_time <= sof_time + 12'h1;
		end
	end

	// Microframe, pad, frame, pad, time
	assign frm_nat = {mfm_cnt, 1'b0, frame_no_r, 4'h0, sof_time};

endmodule

`default_nettype wire

// File: usbf_pl.sv
`default_nettype none

module usbf_pl (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [7:0]                    rx_data,	// UTMI receive
	input  logic                          rx_valid,
	input  logic                          rx_active,
	input  logic                          rx_err,
	input  logic                          mode_hs,	// High speed
	input  logic [6:0]                    fa,
	output logic [usbf_pkg::mem_aw-1:0]    madr,
	output logic [31:0]                   mdout,
	output logic                          mwe,
	output logic                          mreq,
	input  logic                          mack,
	output logic [3:0]                    ep_sel,
	output logic                          token_valid,
	output logic                          token_match,
	output logic                          pid_cs_err,
	output logic                          crc5_err,
	output logic                          unsupported_pid,
	output logic                          drop_err,
	output logic                          idma_done,
	output logic [usbf_pkg::frm_nat_w-1:0] frm_nat
);

	usbf_pkg::token_field_t token_field;
	logic [7:0] pd_data, fifo_data;
	logic       pd_last, pd_valid, fifo_ready;
	logic       fifo_last, fifo_valid, dma_ready;
	logic       sof_we;

	assign ep_sel = token_field.tok.endp;

	// Packet decoder
	usbf_pd u_pd (
		.clk             (clk),
		.rst             (rst),
		.rx_data         (rx_data),
		.rx_valid        (rx_valid),
		.rx_active       (rx_active),
		.rx_err          (rx_err),
		.fa              (fa),
		.mode_hs         (mode_hs),
		.fifo_ready      (fifo_ready),
		.pd_data         (pd_data),
		.pd_last         (pd_last),
		.pd_valid        (pd_valid),
		.token_field     (token_field),
		.token_pid       (),	// For a protocol engine
		.token_valid     (token_valid),
		.token_match     (token_match),
		.sof_we          (sof_we),
		.pid_cs_err      (pid_cs_err),
		.crc5_err        (crc5_err),
		.unsupported_pid (unsupported_pid),
		.drop_err        (drop_err)
	);

	usbf_rx_fifo u_fifo (
		.clk      (clk),
		.rst      (rst),
		.wr_data  (pd_data),
		.wr_last  (pd_last),
		.wr_valid (pd_valid),
		.wr_ready (fifo_ready),
		.rd_data  (fifo_data),
		.rd_last  (fifo_last),
		.rd_valid (fifo_valid),
		.rd_ready (dma_ready)
	);

	// Bytes to memory words
	usbf_idma u_idma (
		.clk       (clk),
		.rst       (rst),
		.in_data   (fifo_data),
		.in_last   (fifo_last),
		.in_valid  (fifo_valid),
		.in_ready  (dma_ready),
		.madr      (madr),
		.mdout     (mdout),
		.mwe       (mwe),
		.mreq      (mreq),
		.mack      (mack),
		.idma_done (idma_done)
	);

	usbf_frame u_frame (
		.clk         (clk),
		.rst         (rst),
		.sof_we      (sof_we),
		.token_field (token_field),
		.frm_nat     (frm_nat)
	);

endmodule

`default_nettype wire

// File: tb_usbf_pl.sv
`default_nettype none

module tb_usbf_pl;

	localparam logic [1:0] k_tok    = 2'd0;	// PID and two token bytes
	localparam logic [1:0] k_dat    = 2'd1;	// PID, payload, CRC16 filler
	localparam logic [1:0] k_pid    = 2'd2;	// Lone PID byte
	localparam logic [6:0] fa_me    = 7'h2a;
	localparam logic [6:0] fa_other = 7'h15;
	localparam int         tmo      = 300;	// Cycles allowed per wait

	// First five counter slots follow the flags field order
	localparam int c_tv = 0, c_tm = 1, c_crc = 2, c_cs = 3, c_un = 4, c_done = 5, c_drop = 6;

	typedef struct packed {
		logic [1:0]  kind;
		logic [3:0]  pid;
		logic [10:0] fld;	// {endp, addr} or frame number
		logic [3:0]  len;	// Payload bytes
		logic [2:0]  opt;	// {bad crc5, bad check nibble, mode_hs}
		logic [4:0]  flags;	// {valid, match, crc5, pid check, unsupported}
		logic [3:0]  mfm;	// Microframe count after an SOF
	} entry_t;

	logic        clk, rst, rx_valid, rx_active, rx_err, mode_hs;
	logic [7:0]  rx_data;
	logic [6:0]  fa;
	logic        mack = 1'b0;
	logic [usbf_pkg::mem_aw-1:0] madr;
	logic [31:0] mdout;
	logic        mwe, mreq, token_valid, token_match, pid_cs_err, crc5_err;
	logic        unsupported_pid, drop_err, idma_done;
	logic [3:0]  ep_sel;
	logic [31:0] frm_nat;

	entry_t      tbl[$];
	logic [7:0]  pkt[$];	// Bytes of the packet being sent
	logic [7:0]  pl[16];	// Payload of the last data packet
	logic [usbf_pkg::mem_aw-1:0] wr_adr_q[$];
	logic [31:0] wr_dat_q[$];
	int          cnt[7];	// Running event counts
	int          base[7];	// Counts at start of a test
	int          dly[64];	// mack delays
	int          seed = 70368;
	int          ack_idx = 0;
	int          ack_left = 0;
	logic        ack_busy = 1'b0;
	int          errors = 0;
	int          checks = 0;
	int          cur = 0;
	logic        armed;	// Matching OUT/SETUP seen
	logic [usbf_pkg::mem_aw-1:0] exp_adr;
	string       ev_nm[7] = '{"token_valid", "token_match", "crc5_err", "pid_cs_err",
		"unsupported_pid", "idma_done", "drop_err"};

	usbf_pl uut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Pulse counts sample the values held before the edge
	always @(posedge clk) begin
		cnt[c_tv]   += int'(token_valid);
		cnt[c_tm]   += int'(token_match);
		cnt[c_crc]  += int'(crc5_err);
		cnt[c_cs]   += int'(pid_cs_err);
		cnt[c_un]   += int'(unsupported_pid);
		cnt[c_done] += int'(idma_done);
		cnt[c_drop] += int'(drop_err);
	end

	// Memory acks after 0 to 5 cycles and logs each word
	always @(negedge clk) begin
		// Write enable rises and falls with the request
		if (mreq || mwe)
			check_eq(int'(mwe), int'(mreq), "mwe");
		if (mack) begin
			mack = 1'b0;	// Single cycle ack
		end else if (mreq) begin
			if (!ack_busy) begin
				ack_busy = 1'b1;
				ack_left = dly[ack_idx % 64];
				ack_idx++;
			end
			if (ack_left == 0) begin
				mack     = 1'b1;
				ack_busy = 1'b0;
				wr_adr_q.push_back(madr);	// Stable while mreq high
				wr_dat_q.push_back(mdout);
			end else begin
				ack_left--;
			end
		end
	end

	// CRC5 of token bits LSB first with preset ones and inverted result
	function automatic logic [4:0] token_crc5(input logic [10:0] bits);
		logic [4:0] r;
		logic       x;
		r = 5'h1f;
		for (int i = 0; i < 11; i++) begin
			x = bits[i] ^ r[4];
			r = {r[3:0], 1'b0};
			if (x)
				r = r ^ 5'h05;
		end
		return ~r;
	endfunction

	task automatic check_eq(input int got, input int want, input string what);
		checks++;
		assert (got == want)
		else begin
			$display("ERR %0t: test %0d %s is %0h, expected %0h", $time, cur, what, got, want);
			errors++;
		end
	endtask

	task automatic add_entry(input logic [1:0] kind, input logic [3:0] pid,
		input logic [10:0] fld, input logic [3:0] len, input logic [2:0] opt,
		input logic [4:0] flags, input logic [3:0] mfm);
		entry_t e;
		e = '{kind, pid, fld, len, opt, flags, mfm};
		tbl.push_back(e);
	endtask

	// Serialize one table entry into UTMI bytes
	task automatic build_packet(input entry_t e);
		logic [4:0] crc;
		logic [7:0] b;
		pkt.delete();
		if (e.opt[1])
			pkt.push_back({e.pid, e.pid});	// Check nibble not inverted
		else
			pkt.push_back({~e.pid, e.pid});
		if (e.kind == k_tok) begin
			crc = token_crc5(e.fld);
			if (e.opt[2])
				crc[2] = ~crc[2];	// One corrupted CRC bit
			pkt.push_back(e.fld[7:0]);
			pkt.push_back({crc, e.fld[10:8]});
		end else if (e.kind == k_dat) begin
			for (int k = 0; k < int'(e.len); k++) begin
				b = 8'($random(seed));
				pl[k] = b;
				pkt.push_back(b);
			end
			pkt.push_back(8'h5a);	// CRC16 filler
			pkt.push_back(8'hc3);
		end
	endtask

	// One byte per cycle until rx_active drops
	task automatic send_packet();
		foreach (pkt[j]) begin
			rx_active = 1'b1;
			rx_valid  = 1'b1;
			rx_data   = pkt[j];
			@(negedge clk);
		end
		rx_active = 1'b0;
		rx_valid  = 1'b0;
		rx_data   = 8'h00;
		@(negedge clk);
	endtask

	task automatic wait_event(input int k);
		int t;
		t = 0;
		while (cnt[k] == base[k] && t < tmo) begin
			@(negedge clk);
			t++;
		end
		if (cnt[k] == base[k]) begin
			$display("Timeout: test %0d saw no %s within %0d cycles", cur, ev_nm[k], tmo);
			errors++;
		end
	endtask

	task automatic run_entry(input int i);
		entry_t      e;
		int          e0, w0, nw, wait_k;
		logic [31:0] w;
		e       = tbl[i];
		cur     = i;
		e0      = errors;
		mode_hs = e.opt[0];
		for (int k = 0; k < 7; k++)
			base[k] = cnt[k];
		w0     = wr_dat_q.size();
		nw     = (e.kind == k_dat && armed) ? (int'(e.len) + 3) / 4 : 0;
		wait_k = -1;
		if (e.kind == k_tok)
			wait_k = e.opt[1] ? c_cs : c_tv;
		else if (e.kind == k_pid && e.flags[0])
			wait_k = c_un;
		else if (nw > 0)
			wait_k = c_done;
		build_packet(e);
		send_packet();
		if (wait_k >= 0)
			wait_event(wait_k);
		repeat (wait_k >= 0 ? 6 : 16) @(negedge clk);	// Longer window when nothing is due
		for (int k = 0; k < 5; k++)
			check_eq(cnt[k] - base[k], int'(e.flags[4 - k]), ev_nm[k]);
		check_eq(cnt[c_drop] - base[c_drop], 0, "drop_err");
		if (e.kind == k_tok && !e.opt[1]) begin
			if (!e.opt[2] && e.pid != usbf_pkg::pid_sof)
				check_eq(int'(ep_sel), int'(e.fld[10:7]), "ep_sel");
			if (!e.opt[2] && e.pid == usbf_pkg::pid_sof) begin
				check_eq(int'(frm_nat[31:28]), int'(e.mfm), "microframe count");
				check_eq(int'(frm_nat[26:16]), int'(e.fld), "frame number");
			end
			// Any complete token decides the next data packet
			armed = (e.pid == usbf_pkg::pid_out || e.pid == usbf_pkg::pid_setup) &&
				e.fld[6:0] == fa_me && !e.opt[2];
		end
		if (e.kind == k_dat) begin
			check_eq(wr_dat_q.size() - w0, nw, "memory writes");
			check_eq(cnt[c_done] - base[c_done], nw > 0 ? 1 : 0, "idma_done pulses");
			for (int k = 0; k < nw && w0 + k < wr_dat_q.size(); k++) begin
				w = 32'h0;	// Unused lanes stay zero
				for (int b = 0; b < 4; b++)
					if (4 * k + b < int'(e.len))
						w[8 * b +: 8] = pl[4 * k + b];
				check_eq(int'(wr_adr_q[w0 + k]), int'(exp_adr), "write address");
				check_eq(wr_dat_q[w0 + k], w, "write data");
				exp_adr++;
			end
			armed = 1'b0;
		end
		$display("test %0d kind %0d pid %h: %s", i, e.kind, e.pid,
			errors == e0 ? "ok" : "mismatch");
	endtask

	initial begin
		rst       = 1'b0;
		rx_data   = 8'h00;
		rx_valid  = 1'b0;
		rx_active = 1'b0;
		rx_err    = 1'b0;
		mode_hs   = 1'b1;
		fa        = fa_me;
		armed     = 1'b0;
		exp_adr   = '0;
		for (int k = 0; k < 64; k++)
			dly[k] = ($random(seed) & 32'h7fff_ffff) % 6;
		add_entry(k_tok, usbf_pkg::pid_out, {4'd3, fa_me}, 4'd0, 3'b001, 5'b11000, 4'd0);
		add_entry(k_dat, usbf_pkg::pid_data0, 11'h0, 4'd5, 3'b001, 5'b00000, 4'd0);
		add_entry(k_tok, usbf_pkg::pid_out, {4'd1, fa_me}, 4'd0, 3'b001, 5'b11000, 4'd0);
		add_entry(k_dat, usbf_pkg::pid_data1, 11'h0, 4'd0, 3'b001, 5'b00000, 4'd0);
		add_entry(k_tok, usbf_pkg::pid_setup, {4'd0, fa_me}, 4'd0, 3'b001, 5'b11000, 4'd0);
		add_entry(k_dat, usbf_pkg::pid_data0, 11'h0, 4'd8, 3'b001, 5'b00000, 4'd0);
		add_entry(k_tok, usbf_pkg::pid_out, {4'd2, fa_me}, 4'd0, 3'b001, 5'b11000, 4'd0);
		add_entry(k_dat, usbf_pkg::pid_data1, 11'h0, 4'd1, 3'b001, 5'b00000, 4'd0);
		add_entry(k_tok, usbf_pkg::pid_out, {4'd5, fa_me}, 4'd0, 3'b001, 5'b11000, 4'd0);
		add_entry(k_dat, usbf_pkg::pid_data0, 11'h0, 4'd9, 3'b001, 5'b00000, 4'd0);
		add_entry(k_tok, usbf_pkg::pid_out, {4'd3, fa_other}, 4'd0, 3'b001, 5'b10000, 4'd0);
		add_entry(k_dat, usbf_pkg::pid_data0, 11'h0, 4'd4, 3'b001, 5'b00000, 4'd0);
		add_entry(k_tok, usbf_pkg::pid_in, {4'd6, fa_me}, 4'd0, 3'b001, 5'b11000, 4'd0);
		add_entry(k_dat, usbf_pkg::pid_data1, 11'h0, 4'd2, 3'b001, 5'b00000, 4'd0);
		add_entry(k_tok, usbf_pkg::pid_out, {4'd3, fa_me}, 4'd0, 3'b101, 5'b10100, 4'd0);
		add_entry(k_tok, usbf_pkg::pid_out, {4'd3, fa_me}, 4'd0, 3'b011, 5'b00010, 4'd0);
		add_entry(k_dat, usbf_pkg::pid_data0, 11'h0, 4'd3, 3'b001, 5'b00000, 4'd0);
		add_entry(k_tok, usbf_pkg::pid_sof, 11'h123, 4'd0, 3'b001, 5'b10000, 4'd0);
		add_entry(k_tok, usbf_pkg::pid_sof, 11'h123, 4'd0, 3'b001, 5'b10000, 4'd1);
		add_entry(k_tok, usbf_pkg::pid_sof, 11'h124, 4'd0, 3'b001, 5'b10000, 4'd0);
		add_entry(k_pid, usbf_pkg::pid_ack, 11'h0, 4'd0, 3'b001, 5'b00001, 4'd0);
		add_entry(k_pid, usbf_pkg::pid_ping, 11'h0, 4'd0, 3'b001, 5'b00000, 4'd0);
		add_entry(k_pid, usbf_pkg::pid_ping, 11'h0, 4'd0, 3'b000, 5'b00001, 4'd0);
		add_entry(k_tok, usbf_pkg::pid_out, {4'd7, fa_me}, 4'd0, 3'b001, 5'b11000, 4'd0);
		add_entry(k_dat, usbf_pkg::pid_mdata, 11'h0, 4'd7, 3'b001, 5'b00000, 4'd0);
		repeat (3) @(negedge clk);
		rst = 1'b1;
		repeat (2) @(negedge clk);
		for (int i = 0; i < tbl.size(); i++)
			run_entry(i);
		$display("%0d tests, %0d checks, %0d errors", tbl.size(), checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: usbf_pl.f
usbf_pkg.sv
usbf_pd.sv
usbf_rx_fifo.sv
usbf_idma.sv
usbf_frame.sv
usbf_pl.sv
tb_usbf_pl.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_usbf_pl \
	-f usbf_pl.f -o tb_usbf_pl \
	&& ./obj_dir/tb_usbf_pl > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation reported errors"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "No result line in log"; exit 1; }
exit 0
